//--- src/an_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Config word, state and status types plus shared constants
// for the 1000BASE-X auto-negotiation block, imported by RTL
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package an_pkg;

   // Base page config word, bit 15 first
   typedef struct packed {
      logic       np;
      logic       ack;
      // RF2 then RF1
      logic [1:0] rf;
      logic [2:0] rsv_hi;
      // PS2 then PS1
      logic [1:0] ps;
      logic       hd;
      logic       fd;
      logic [4:0] rsv_lo;
   } cfg_word_t;

   // Higher encoding means further along
   typedef enum logic [2:0] {
      AN_RESTART = 3'd0,
      AN_ABILITY = 3'd1,
      AN_ACK     = 3'd2,
      AN_IDLE    = 3'd3,
      AN_LINK_OK = 3'd4,
      AN_ABORT   = 3'd5
   } an_state_t;

   // Nine status bits, abort first
   typedef struct packed {
      logic       abort;
      logic       ability;
      logic       wdog_disable;
      logic [1:0] remote_fault;
      logic       abl_mismatch;
      logic       ack;
      logic       idle;
      logic       link_ok;
   } an_status_t;

   // Equal words before acceptance
   localparam int unsigned MATCH_COUNT     = 3;
   // Zero words that request a restart
   localparam int unsigned BREAKLINK_COUNT = 3;
   // Watchdog length in link timer periods
   localparam int unsigned WDOG_FACTOR     = 8;
   localparam int unsigned TIMER_W         = 21;
   localparam int unsigned WDOG_W          = TIMER_W + 3;
   localparam int unsigned MATCH_CNT_W     = $clog2(MATCH_COUNT + 1);
   localparam int unsigned BREAK_CNT_W     = $clog2(BREAKLINK_COUNT + 1);

   // Full duplex only, nothing else advertised
   localparam cfg_word_t LOCAL_ABILITY = '{
      np:     1'b0,
      ack:    1'b0,
      rf:     2'b00,
      rsv_hi: 3'b000,
      ps:     2'b00,
      hd:     1'b0,
      fd:     1'b1,
      rsv_lo: 5'b00000
   };

endpackage

`default_nettype wire

//--- src/cfg_word_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive side of auto-negotiation with link detect, word match,
// ability and ACK capture and breaklink detect for the FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cfg_word_rx
   import an_pkg::*;
(
   input  wire            rx_clk,
   input  wire            an_rst,
   input  wire            los,
   input  wire cfg_word_t lacr_in,
   input  wire            lacr_in_stb,
   input  wire an_state_t an_state,
   output logic           link_det,
   output logic           abl_match,
   output logic           ack_match,
   output logic           consistency_match,
   output logic           breaklink_restart,
   output cfg_word_t      partner_word
);

   cfg_word_t              prev_word;
   cfg_word_t              ability;
   cfg_word_t              in_masked;
   cfg_word_t              prev_masked;
   logic [MATCH_CNT_W-1:0] match_cnt;
   logic [BREAK_CNT_W-1:0] zero_cnt;
   logic                   word_eq;
   logic                   match_ok;
   logic                   in_restart;

   assign in_restart = (an_state == AN_RESTART);
   assign match_ok   = (match_cnt == MATCH_CNT_W'(MATCH_COUNT));

   // Compare with ACK masked off on both sides
   always_comb begin
      in_masked       = lacr_in;
      in_masked.ack   = 1'b0;
      prev_masked     = prev_word;
      prev_masked.ack = 1'b0;
      word_eq         = (in_masked == prev_masked);
   end

   // Any strobe means a partner is there and loss of signal drops it
   always_ff @(posedge rx_clk) begin
      if (an_rst || los) begin
         link_det <= 1'b0;
      end else if (lacr_in_stb) begin
         link_det <= 1'b1;
      end
   end

   // Run length of equal words is held at zero during restart
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         prev_word <= '0;
         match_cnt <= '0;
      end else if (in_restart) begin
         match_cnt <= '0;
      end else if (lacr_in_stb) begin
         prev_word <= lacr_in;
         // New word starts a fresh run unless it extends the current one
         if (word_eq && !match_ok) begin
            match_cnt <= match_cnt + 1'b1;
         end else begin
            match_cnt <= MATCH_CNT_W'(1);
         end
      end else if (match_ok) begin
         match_cnt <= '0;
      end
   end

   // Ability and ACK flags clear whenever negotiation restarts
   always_ff @(posedge rx_clk) begin
      if (an_rst || in_restart) begin
         abl_match         <= 1'b0;
         ack_match         <= 1'b0;
         consistency_match <= 1'b0;
      end else if (match_ok) begin
         // All-zero word is breaklink and never an ability
         if (an_state == AN_ABILITY && !prev_word.ack && prev_word != '0) begin
            abl_match <= 1'b1;
         end
         if (an_state == AN_ACK && prev_word.ack) begin
            ack_match         <= 1'b1;
            consistency_match <= (prev_word == ability);
         end
      end
   end

   // Latched ability is kept with ACK set for the consistency compare
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         ability <= '0;
      end else if (match_ok && an_state == AN_ABILITY && !prev_word.ack) begin
         ability     <= prev_word;
         ability.ack <= 1'b1;
      end
   end

   // Last accepted word feeds the partner status bits
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         partner_word <= '0;
      end else if (match_ok && !in_restart) begin
         partner_word <= prev_word;
      end
   end

   // Zero word run saturates so a long breaklink pulses once
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         zero_cnt          <= '0;
         breaklink_restart <= 1'b0;
      end else begin
         breaklink_restart <= 1'b0;
         if (lacr_in_stb) begin
            if (lacr_in == '0) begin
               if (zero_cnt != BREAK_CNT_W'(BREAKLINK_COUNT)) begin
                  zero_cnt <= zero_cnt + 1'b1;
               end
               breaklink_restart <= (zero_cnt == BREAK_CNT_W'(BREAKLINK_COUNT - 1));
            end else begin
               zero_cnt <= '0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- src/an_timers.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link timer and negotiation watchdog, started and cleared
// by the auto-negotiation FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module an_timers
   import an_pkg::*;
#(
   parameter int unsigned link_timer_ticks = 1_250_000
) (
   input  wire  rx_clk,
   input  wire  an_rst,
   input  wire  los,
   input  wire  timer_start,
   input  wire  wdog_clear,
   input  wire  wdog_run,
   output logic timer_on,
   output logic timer_done,
   output logic wdog_timeout,
   output logic wdog_disable
);

   logic [TIMER_W-1:0] timer_cnt;
   logic [WDOG_W-1:0]  wdog_cnt;

   // Done pulses in the last counting cycle, link_timer_ticks after start
   assign timer_done = timer_on && (timer_cnt == TIMER_W'(1));

   // A new start reloads the down-counter even mid-count
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         timer_on <= 1'b0;
      end else if (timer_start) begin
         timer_on <= 1'b1;
      end else if (timer_done) begin
         timer_on <= 1'b0;
      end
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         timer_cnt <= '0;
      end else if (timer_start) begin
         timer_cnt <= TIMER_W'(link_timer_ticks);
      end else if (timer_on) begin
         timer_cnt <= timer_cnt - 1'b1;
      end
   end

   // Watchdog
   // Counts while negotiating with a partner present
   // Timeout pulses once, then the disable latch freezes the count
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         wdog_cnt     <= '0;
         wdog_timeout <= 1'b0;
         wdog_disable <= 1'b0;
      end else begin
         wdog_timeout <= 1'b0;
         if (wdog_clear || los) begin
            wdog_cnt     <= '0;
            wdog_disable <= 1'b0;
         end else if (wdog_run && !wdog_disable) begin
            if (wdog_cnt == WDOG_W'(WDOG_FACTOR * link_timer_ticks - 1)) begin
               wdog_cnt     <= '0;
               wdog_timeout <= 1'b1;
               wdog_disable <= 1'b1;
            end else begin
               wdog_cnt <= wdog_cnt + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- src/an_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clause 37 style negotiation FSM with registered send,
// operate and status outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module an_fsm
   import an_pkg::*;
(
   input  wire            rx_clk,
   input  wire            an_rst,
   input  wire            los,
   input  wire            link_det,
   input  wire            abl_match,
   input  wire            ack_match,
   input  wire            consistency_match,
   input  wire            breaklink_restart,
   input  wire cfg_word_t partner_word,
   input  wire            timer_on,
   input  wire            timer_done,
   input  wire            wdog_timeout,
   input  wire            wdog_disable,
   output an_state_t      an_state,
   output logic           timer_start,
   output logic           wdog_clear,
   output logic           wdog_run,
   output logic           send_ack,
   output logic           send_breaklink,
   output logic           lacr_send,
   output logic           operate,
   output an_status_t     an_status
);

   an_state_t next_state;
   an_state_t prev_state;
   logic      force_restart;
   logic      entered;
   logic      timer_free;
   logic      timer_go;
   logic      n_lacr_send;
   logic      n_operate;

   // Breaklink is ignored once the watchdog has given up
   assign force_restart = (breaklink_restart && !wdog_disable) || los || wdog_timeout;

   // First cycle in a state always restarts the link timer
   assign entered    = (an_state != prev_state);
   assign timer_free = !timer_on && !timer_done;
   assign timer_go   = timer_done && !entered;

   // Forward progress or loss of signal clears the watchdog
   assign wdog_clear = ((next_state > an_state) && (an_state != AN_RESTART)) || los;
   assign wdog_run   = link_det && (an_state != AN_LINK_OK);

   always_comb begin
      next_state  = an_state;
      n_lacr_send = 1'b0;
      n_operate   = 1'b0;
      timer_start = 1'b0;
      case (an_state)
         AN_RESTART: begin
            // Breaklink for one full link timer with a partner seen
            n_lacr_send = 1'b1;
            timer_start = entered || timer_free;
            if (timer_go && link_det) begin
               next_state = wdog_disable ? AN_ABORT : AN_ABILITY;
            end
         end
         AN_ABILITY: begin
            n_lacr_send = 1'b1;
            if (abl_match) begin
               next_state = AN_ACK;
            end
         end
         AN_ACK: begin
            // Send ACK for a link timer, then judge the partner
            n_lacr_send = 1'b1;
            timer_start = entered || timer_free;
            if (timer_go && ack_match) begin
               next_state = consistency_match ? AN_IDLE : AN_RESTART;
            end
         end
         AN_IDLE: begin
            // No idle check, just the timer
            timer_start = entered || timer_free;
            if (timer_go) begin
               next_state = AN_LINK_OK;
            end
         end
         AN_LINK_OK: begin
            n_operate = 1'b1;
         end
         AN_ABORT: begin
            // Run without negotiation, nothing sent
            n_operate = 1'b1;
         end
         default: begin
            next_state = AN_RESTART;
         end
      endcase
      if (force_restart) begin
         next_state = AN_RESTART;
      end
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         an_state   <= AN_RESTART;
         prev_state <= AN_RESTART;
      end else begin
         an_state   <= next_state;
         prev_state <= an_state;
      end
   end

   // Word select follows the state, so lacr_out lines up with lacr_send
   // Reset value matches the restart state
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         send_breaklink <= 1'b1;
         send_ack       <= 1'b0;
      end else begin
         send_breaklink <= (next_state == AN_RESTART);
         send_ack       <= (next_state == AN_ACK) || (next_state == AN_IDLE) ||
                           (next_state == AN_LINK_OK);
      end
   end

   // Controls and status one cycle behind the state
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_send <= 1'b0;
         operate   <= 1'b0;
         an_status <= '0;
      end else begin
         lacr_send                 <= n_lacr_send;
         operate                   <= n_operate;
         an_status.abort           <= (an_state == AN_ABORT);
         an_status.ability         <= (an_state == AN_ABILITY);
         an_status.wdog_disable    <= wdog_disable;
         an_status.remote_fault    <= partner_word.rf;
         // Partner lacks full duplex
         an_status.abl_mismatch    <= ~partner_word.fd;
         an_status.ack             <= (an_state == AN_ACK);
         an_status.idle            <= (an_state == AN_IDLE);
         an_status.link_ok         <= (an_state == AN_LINK_OK);
      end
   end

endmodule

`default_nettype wire

//--- src/cfg_word_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Outgoing config word built from the local ability
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cfg_word_tx
   import an_pkg::*;
(
   input  wire       rx_clk,
   input  wire       an_rst,
   input  wire       send_ack,
   input  wire       send_breaklink,
   output cfg_word_t lacr_out
);

   cfg_word_t word_next;

   // Zero word during breaklink, else ability with our ACK
   always_comb begin
      if (send_breaklink) begin
         word_next = '0;
      end else begin
         word_next     = LOCAL_ABILITY;
         word_next.ack = send_ack;
      end
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_out <= '0;
      end else begin
         lacr_out <= word_next;
      end
   end

endmodule

`default_nettype wire

//--- src/pcs_autoneg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 1000BASE-X PCS auto-negotiation top, all on rx_clk
// Set link_timer_ticks short for simulation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pcs_autoneg
   import an_pkg::*;
#(
   // 10 ms at 125 MHz
   parameter int unsigned link_timer_ticks = 1_250_000
) (
   input  wire            rx_clk,
   input  wire            an_rst,
   input  wire            los,
   input  wire cfg_word_t lacr_in,
   input  wire            lacr_in_stb,
   output cfg_word_t      lacr_out,
   output logic           lacr_send,
   output logic           operate,
   output an_status_t     an_status
);

   an_state_t an_state;
   cfg_word_t partner_word;
   logic      link_det;
   logic      abl_match;
   logic      ack_match;
   logic      consistency_match;
   logic      breaklink_restart;
   logic      timer_start;
   logic      timer_on;
   logic      timer_done;
   logic      wdog_clear;
   logic      wdog_run;
   logic      wdog_timeout;
   logic      wdog_disable;
   logic      send_ack;
   logic      send_breaklink;

   // Partner word match and capture
   cfg_word_rx u_rx (
      .rx_clk            (rx_clk),
      .an_rst            (an_rst),
      .los               (los),
      .lacr_in           (lacr_in),
      .lacr_in_stb       (lacr_in_stb),
      .an_state          (an_state),
      .link_det          (link_det),
      .abl_match         (abl_match),
      .ack_match         (ack_match),
      .consistency_match (consistency_match),
      .breaklink_restart (breaklink_restart),
      .partner_word      (partner_word)
   );

   an_timers #(
      .link_timer_ticks (link_timer_ticks)
   ) u_timers (
      .rx_clk       (rx_clk),
      .an_rst       (an_rst),
      .los          (los),
      .timer_start  (timer_start),
      .wdog_clear   (wdog_clear),
      .wdog_run     (wdog_run),
      .timer_on     (timer_on),
      .timer_done   (timer_done),
      .wdog_timeout (wdog_timeout),
      .wdog_disable (wdog_disable)
   );

   an_fsm u_fsm (
      .rx_clk            (rx_clk),
      .an_rst            (an_rst),
      .los               (los),
      .link_det          (link_det),
      .abl_match         (abl_match),
      .ack_match         (ack_match),
      .consistency_match (consistency_match),
      .breaklink_restart (breaklink_restart),
      .partner_word      (partner_word),
      .timer_on          (timer_on),
      .timer_done        (timer_done),
      .wdog_timeout      (wdog_timeout),
      .wdog_disable      (wdog_disable),
      .an_state          (an_state),
      .timer_start       (timer_start),
      .wdog_clear        (wdog_clear),
      .wdog_run          (wdog_run),
      .send_ack          (send_ack),
      .send_breaklink    (send_breaklink),
      .lacr_send         (lacr_send),
      .operate           (operate),
      .an_status         (an_status)
   );

   // Outgoing word
   cfg_word_tx u_tx (
      .rx_clk         (rx_clk),
      .an_rst         (an_rst),
      .send_ack       (send_ack),
      .send_breaklink (send_breaklink),
      .lacr_out       (lacr_out)
   );

endmodule

`default_nettype wire

//--- testbench/an_partner_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link partner for the testbench, strobes the selected
// config word into the DUT once every four cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module an_partner_model
   import an_pkg::*;
(
   input  wire            rx_clk,
   input  wire            an_rst,
   input  wire cfg_word_t tx_word,
   output cfg_word_t      lacr_in,
   output logic           lacr_in_stb
);

   logic [1:0] gap_cnt;

   // Known values before the first clock edge
   initial begin
      gap_cnt     = '0;
      lacr_in     = '0;
      lacr_in_stb = 1'b0;
   end

   // One strobe per four cycles, word sampled at the strobe
   always @(posedge rx_clk) begin
      if (an_rst) begin
         gap_cnt     <= '0;
         lacr_in     <= '0;
         lacr_in_stb <= 1'b0;
      end else begin
         gap_cnt     <= gap_cnt + 1'b1;
         lacr_in_stb <= (gap_cnt == 2'd3);
         if (gap_cnt == 2'd3) begin
            lacr_in <= tx_word;
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_pcs_autoneg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for pcs_autoneg running six negotiation scenarios
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_pcs_autoneg
   import an_pkg::*;
();

   // Six tests at up to about 1500 cycles each, plus margin
   localparam int unsigned CYCLE_LIMIT = 20000;
   localparam int unsigned TICKS       = 64;

   logic       rx_clk;
   logic       an_rst;
   logic       los;
   cfg_word_t  partner_tx;
   cfg_word_t  lacr_in;
   logic       lacr_in_stb;
   cfg_word_t  lacr_out;
   logic       lacr_send;
   logic       operate;
   an_status_t an_status;
   cfg_word_t  ack_ability;
   logic       in_restart;
   logic       operate_seen;
   int unsigned err_count;
   int unsigned test_count;
   int unsigned cycles;

   pcs_autoneg #(.link_timer_ticks(TICKS)) UUT (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .los         (los),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb),
      .lacr_out    (lacr_out),
      .lacr_send   (lacr_send),
      .operate     (operate),
      .an_status   (an_status)
   );

   an_partner_model u_partner (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .tx_word     (partner_tx),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb)
   );

   // Expected word once the link is up, full duplex only with ACK
   always_comb begin
      ack_ability     = '0;
      ack_ability.fd  = 1'b1;
      ack_ability.ack = 1'b1;
   end

   // Restart shows as sending with no state bit in the status
   assign in_restart = lacr_send && !an_status.ability && !an_status.ack &&
                       !an_status.idle && !an_status.link_ok && !an_status.abort;

   task automatic report_fail(input string msg);
      err_count++;
      $display("FAIL @%0t ns: %s", $time, msg);
   endtask

   restart_sends_zero: assert property (@(posedge rx_clk) disable iff (an_rst)
      in_restart |-> (lacr_out == '0))
      else report_fail("lacr_out not zero while sending in restart");

   operate_follows_state: assert property (@(posedge rx_clk) disable iff (an_rst)
      operate == (an_status.link_ok || an_status.abort))
      else report_fail("operate differs from link_ok or abort");

   link_ok_word: assert property (@(posedge rx_clk) disable iff (an_rst)
      an_status.link_ok |-> (lacr_out == ack_ability && !lacr_send))
      else report_fail("wrong word or lacr_send high in link-OK");

   // Link-OK is only reached through idle
   idle_before_link_ok: assert property (@(posedge rx_clk) disable iff (an_rst)
      $rose(an_status.link_ok) |-> $past(an_status.idle))
      else report_fail("link-OK entered without idle first");

   abort_quiet: assert property (@(posedge rx_clk) disable iff (an_rst)
      an_status.abort |-> (!lacr_send && an_status.wdog_disable))
      else report_fail("lacr_send high or watchdog clear in abort");

   reset_quiet: assert property (@(posedge rx_clk)
      an_rst |=> (!operate && !lacr_send && lacr_out == '0 && an_status == '0))
      else report_fail("outputs not cleared by reset");

   initial begin
      rx_clk = 1'b0;
      forever begin
         #50 rx_clk = ~rx_clk;
      end
   end

   // Global cycle limit bounds every wait loop
   initial begin
      cycles = 0;
      forever begin
         @(posedge rx_clk);
         cycles++;
         if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
         end
      end
   end

   always @(posedge rx_clk) begin
      if (an_rst) begin
         operate_seen <= 1'b0;
      end else if (operate) begin
         operate_seen <= 1'b1;
      end
   end

   task automatic apply_reset();
      @(posedge rx_clk);
      an_rst     <= 1'b1;
      los        <= 1'b0;
      partner_tx <= '0;
      repeat (10) @(posedge rx_clk);
      an_rst <= 1'b0;
   endtask

   task automatic set_word(input cfg_word_t w);
      @(posedge rx_clk);
      partner_tx <= w;
   endtask

   // Counts strobes seen at the falling edge
   task automatic wait_strobes(input int n);
      repeat (n) begin
         @(negedge rx_clk);
         while (!lacr_in_stb) @(negedge rx_clk);
      end
   endtask

   // Ability first, then the acknowledged word
   task automatic negotiate(input cfg_word_t abl, input cfg_word_t ackw);
      @(negedge rx_clk);
      while (!an_status.ability) @(negedge rx_clk);
      set_word(abl);
      @(negedge rx_clk);
      while (!an_status.ack) @(negedge rx_clk);
      set_word(ackw);
   endtask

   task automatic wait_link_ok();
      @(negedge rx_clk);
      while (!an_status.link_ok) @(negedge rx_clk);
   endtask

   task automatic wait_operate_low();
      @(negedge rx_clk);
      while (operate) @(negedge rx_clk);
   endtask

   task automatic end_test(input string name, input int unsigned err_before);
      test_count++;
      if (err_count == err_before) begin
         $display("Test %0d %s: ok", test_count, name);
      end else begin
         $display("Test %0d %s: %0d errors", test_count, name, err_count - err_before);
      end
   endtask

   // Full duplex with random reserved bits
   function automatic cfg_word_t make_ability(input logic [31:0] r);
      cfg_word_t w;
      w        = '0;
      w.fd     = 1'b1;
      w.rsv_lo = r[4:0];
      w.rsv_hi = r[7:5];
      return w;
   endfunction

   initial begin
      int unsigned err_before;
      int unsigned wait_cyc;
      cfg_word_t   abl;
      cfg_word_t   ackw;
      cfg_word_t   other;
      err_count  = 0;
      test_count = 0;
      an_rst     = 1'b1;
      los        = 1'b0;
      partner_tx = '0;
      void'($urandom(32'h523f));
      abl      = make_ability($urandom());
      ackw     = abl;
      ackw.ack = 1'b1;

      // Normal negotiation measures the ability delay on the way
      err_before = err_count;
      apply_reset();
      wait_cyc = 0;
      @(negedge rx_clk);
      while (!an_status.ability) begin
         wait_cyc++;
         @(negedge rx_clk);
      end
      negotiate(abl, ackw);
      wait_link_ok();
      repeat (40) @(negedge rx_clk);
      assert (operate) else report_fail("operate low in link-OK");
      end_test("normal negotiation", err_before);

      err_before = err_count;
      assert (wait_cyc >= TICKS)
         else report_fail($sformatf("ability after %0d cycles", wait_cyc));
      end_test("link timer length", err_before);

      // Partner acknowledges a different ability
      err_before = err_count;
      apply_reset();
      other    = abl;
      other.ps = 2'b01;
      other.ack = 1'b1;
      negotiate(abl, other);
      @(negedge rx_clk);
      while (!in_restart) @(negedge rx_clk);
      repeat (4) @(negedge rx_clk);
      assert (lacr_out == '0) else report_fail("no zero words after bad ACK");
      assert (!operate_seen) else report_fail("operate rose on bad ACK");
      end_test("inconsistent acknowledge", err_before);

      // Breaklink and loss of signal while the link is up
      err_before = err_count;
      apply_reset();
      negotiate(abl, ackw);
      wait_link_ok();
      wait_strobes(1);
      set_word('0);
      wait_strobes(2);
      set_word(ackw);
      repeat (60) begin
         @(negedge rx_clk);
         assert (operate) else report_fail("two zero words dropped operate");
      end
      wait_strobes(1);
      set_word('0);
      wait_operate_low();
      negotiate(abl, ackw);
      wait_link_ok();
      @(posedge rx_clk);
      los <= 1'b1;
      repeat (2) @(posedge rx_clk);
      los <= 1'b0;
      @(negedge rx_clk);
      assert (!operate) else report_fail("los did not drop operate");
      end_test("restart requests", err_before);

      // Partner never acknowledges
      err_before = err_count;
      apply_reset();
      negotiate(abl, abl);
      wait_cyc = 0;
      @(negedge rx_clk);
      while (!an_status.wdog_disable) begin
         wait_cyc++;
         @(negedge rx_clk);
      end
      assert (wait_cyc <= WDOG_FACTOR * TICKS + TICKS + 20)
         else report_fail($sformatf("watchdog took %0d cycles", wait_cyc));
      @(negedge rx_clk);
      while (!an_status.abort) @(negedge rx_clk);
      @(negedge rx_clk);
      assert (operate && !lacr_send) else report_fail("abort without operate");
      end_test("watchdog", err_before);

      // Half duplex partner with remote fault
      err_before = err_count;
      apply_reset();
      other    = '0;
      other.hd = 1'b1;
      other.rf = 2'b10;
      negotiate(other, other);
      @(negedge rx_clk);
      assert (an_status.abl_mismatch && an_status.remote_fault == 2'b10)
         else report_fail("partner status bits wrong");
      end_test("partner status", err_before);

      $display("Tests run: %0d, errors: %0d", test_count, err_count);
      if (err_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
src/an_pkg.sv
src/cfg_word_rx.sv
src/an_timers.sv
src/an_fsm.sv
src/cfg_word_tx.sv
src/pcs_autoneg.sv
testbench/an_partner_model.sv
testbench/tb_pcs_autoneg.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the auto-negotiation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_pcs_autoneg -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
   exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0
